// File: hdl/cmd_seq_pkg.sv
package cmd_seq_pkg;

    // command memory geometry
    localparam int MEM_DEPTH  = 2048;
    localparam int MEM_ADDR_W = 11;

    // register window, memory sits right above it
    localparam int REG_COUNT = 8;
    localparam int MEM_BASE  = 8;

    // register byte addresses
    typedef enum logic [2:0] {
        REG_SOFT_RST  = 3'd0,
        REG_START     = 3'd1,
        REG_CONF      = 3'd2,
        REG_SIZE_LO   = 3'd3,
        REG_SIZE_HI   = 3'd4,
        REG_REPEAT_LO = 3'd5,
        REG_REPEAT_HI = 3'd6,
        REG_SPARE     = 3'd7
    } reg_addr_e;

    // conf bit 0 ext start enable, bit 1 negedge data
    localparam logic [7:0]  CONF_DEFAULT   = 8'h02;
    // send the pattern once by default
    localparam logic [15:0] REPEAT_DEFAULT = 16'd1;

    // send sequencer states
    typedef enum logic {
        SEQ_WAIT = 1'b0,
        SEQ_SEND = 1'b1
    } seq_state_e;

endpackage

// File: hdl/cmd_cfg_if.sv
`timescale 1ns/1ps

interface cmd_cfg_if;

    // pattern length in bits
    logic [15:0] cmd_size;
    // number of pattern repeats
    logic [15:0] repeat_count;
    // external start pulse allowed
    logic        en_ext_start;
    // launch data on the falling edge
    logic        en_negedge_data;

    // register block owns the whole bundle
    modport regs_mp (
        output cmd_size,
        output repeat_count,
        output en_ext_start,
        output en_negedge_data
    );

    // sequencer needs length, repeats and start enable
    modport ctrl_mp (
        input cmd_size,
        input repeat_count,
        input en_ext_start
    );

    // shifter only picks the launch edge
    modport shift_mp (
        input en_negedge_data
    );

endinterface

// File: hdl/cmd_seq_regs.sv
`timescale 1ns/1ps

module cmd_seq_regs import cmd_seq_pkg::*; (
    input  logic                  CMD_CLK_IN,
    input  logic                  reset_sync,
    input  logic [15:0]           bus_add,
    input  logic [7:0]            bus_data_in,
    input  logic                  bus_rd,
    input  logic                  bus_wr,
    input  logic                  ready,
    input  logic [7:0]            mem_rd_data,
    output logic [7:0]            bus_data_out,
    output logic [MEM_ADDR_W-1:0] mem_rd_addr,
    output logic                  seq_start,
    output logic                  seq_clear,
    cmd_cfg_if.regs_mp            cfg
);

    logic [7:0]  regs [REG_COUNT];
    reg_addr_e   reg_sel;
    logic        add_is_reg;
    logic        add_is_mem;
    logic        reg_wr;
    logic        start_wr;
    logic        soft_rst_wr;
    logic        start_wr_d;
    logic        soft_rst_wr_d;
    logic        rd_mem_d;
    logic [15:0] mem_off;

    // address decode
    assign reg_sel     = reg_addr_e'(bus_add[2:0]);
    assign add_is_reg  = (bus_add < 16'(REG_COUNT));
    assign add_is_mem  = (bus_add >= 16'(MEM_BASE));
    assign reg_wr      = bus_wr && add_is_reg;
    assign start_wr    = reg_wr && (reg_sel == REG_START);
    assign soft_rst_wr = reg_wr && (reg_sel == REG_SOFT_RST);

    // byte index into the command memory
    assign mem_off     = bus_add - 16'(MEM_BASE);
    assign mem_rd_addr = mem_off[MEM_ADDR_W-1:0];

    // register bytes, a soft reset write restores defaults
    always_ff @(posedge CMD_CLK_IN) begin
        if (reset_sync || soft_rst_wr) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= 8'h00;
            end
            regs[REG_CONF]      <= CONF_DEFAULT;
            regs[REG_REPEAT_LO] <= REPEAT_DEFAULT[7:0];
            regs[REG_REPEAT_HI] <= REPEAT_DEFAULT[15:8];
        end else if (reg_wr) begin
            regs[reg_sel] <= bus_data_in;
        end
    end

    // first cycle of a held write gives one registered pulse
    always_ff @(posedge CMD_CLK_IN) begin
        if (reset_sync) begin
            start_wr_d    <= 1'b0;
            soft_rst_wr_d <= 1'b0;
            seq_start     <= 1'b0;
            seq_clear     <= 1'b0;
        end else begin
            start_wr_d    <= start_wr;
            soft_rst_wr_d <= soft_rst_wr;
            seq_start     <= start_wr && !start_wr_d;
            seq_clear     <= soft_rst_wr && !soft_rst_wr_d;
        end
    end

    // memory data lags the address by one clock
    always_ff @(posedge CMD_CLK_IN) begin
        if (reset_sync) begin
            rd_mem_d <= 1'b0;
        end else begin
            rd_mem_d <= bus_rd && add_is_mem;
        end
    end

    // readback, holds between reads
    always_ff @(posedge CMD_CLK_IN) begin
        if (bus_rd) begin
            if (add_is_reg) begin
                if (reg_sel == REG_START) begin
                    bus_data_out <= {7'b0, ready};
                end else begin
                    bus_data_out <= regs[reg_sel];
                end
            end else if (rd_mem_d) begin
                bus_data_out <= mem_rd_data;
            end
        end
    end

    // configuration view of the register bytes
    assign cfg.cmd_size        = {regs[REG_SIZE_HI], regs[REG_SIZE_LO]};
    assign cfg.repeat_count    = {regs[REG_REPEAT_HI], regs[REG_REPEAT_LO]};
    assign cfg.en_ext_start    = regs[REG_CONF][0];
    assign cfg.en_negedge_data = regs[REG_CONF][1];

endmodule

// File: hdl/cmd_seq_mem.sv
`timescale 1ns/1ps

module cmd_seq_mem import cmd_seq_pkg::*; (
    input  logic                  CMD_CLK_IN,
    input  logic [15:0]           bus_add,
    input  logic [7:0]            bus_data_in,
    input  logic                  bus_wr,
    input  logic [MEM_ADDR_W-1:0] mem_rd_addr,
    input  logic [MEM_ADDR_W-1:0] seq_mem_addr,
    output logic [7:0]            mem_rd_data,
    output logic [7:0]            seq_mem_data
);

    logic [7:0]  mem [MEM_DEPTH];
    logic [15:0] wr_off;
    logic        mem_wr;

    // bus writes above the register window
    assign mem_wr = bus_wr && (bus_add >= 16'(MEM_BASE));
    assign wr_off = bus_add - 16'(MEM_BASE);

    always_ff @(posedge CMD_CLK_IN) begin
        if (mem_wr) begin
            mem[wr_off[MEM_ADDR_W-1:0]] <= bus_data_in;
        end
    end

    // host readback port
    always_ff @(posedge CMD_CLK_IN) begin
        mem_rd_data <= mem[mem_rd_addr];
    end

    // sequencer fetch port
    always_ff @(posedge CMD_CLK_IN) begin
        seq_mem_data <= mem[seq_mem_addr];
    end

endmodule

// File: hdl/cmd_seq_ctrl.sv
`timescale 1ns/1ps

module cmd_seq_ctrl import cmd_seq_pkg::*; (
    input  logic                  CMD_CLK_IN,
    input  logic                  reset_sync,
    input  logic                  seq_start,
    input  logic                  seq_clear,
    input  logic                  cmd_ext_start_flag,
    output logic                  ready,
    output logic [MEM_ADDR_W-1:0] seq_mem_addr,
    output logic                  shift_load,
    output logic                  shift_step,
    output logic                  shift_clear,
    output logic                  cmd_ext_start_enable,
    cmd_cfg_if.ctrl_mp            cfg
);

    seq_state_e  state;
    seq_state_e  next_state;
    logic [15:0] bit_cnt;
    logic [15:0] bit_cnt_inc;
    logic [15:0] repeat_cnt;
    logic        send_cmd;
    logic        at_wrap;
    logic        last_bit;
    logic        done;
    logic        sending;

    // register start or gated external pulse
    assign send_cmd = seq_start | (cmd_ext_start_flag & cmd_ext_start_enable);

    // bit_cnt == cmd_size is bit 0 of the next repeat
    assign at_wrap     = (bit_cnt == cfg.cmd_size);
    assign last_bit    = (bit_cnt == cfg.cmd_size - 16'd1);
    assign done        = at_wrap && (repeat_cnt == cfg.repeat_count);
    assign bit_cnt_inc = bit_cnt + 16'd1;

    always_comb begin
        next_state = state;
        case (state)
            SEQ_WAIT: begin
                // zero length never starts
                if (send_cmd && (cfg.cmd_size != 16'd0)) begin
                    next_state = SEQ_SEND;
                end
            end
            SEQ_SEND: begin
                // a start on the last bit keeps sending
                if (done && !send_cmd) begin
                    next_state = SEQ_WAIT;
                end
            end
            default: next_state = SEQ_WAIT;
        endcase
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (reset_sync || seq_clear) begin
            state <= SEQ_WAIT;
        end else begin
            state <= next_state;
        end
    end

    // stays in send for this and the next cycle
    assign sending = (state == SEQ_SEND) && (next_state == SEQ_SEND);

    // bit position, zero outside a send
    always_ff @(posedge CMD_CLK_IN) begin
        if (reset_sync || seq_clear || !sending) begin
            bit_cnt <= 16'd0;
        end else if (at_wrap) begin
            bit_cnt <= 16'd1;
        end else begin
            bit_cnt <= bit_cnt_inc;
        end
    end

    // repeat counter, saturating
    always_ff @(posedge CMD_CLK_IN) begin
        if (reset_sync || seq_clear || send_cmd) begin
            repeat_cnt <= 16'd1;
        end else if ((state == SEQ_SEND) && at_wrap && (repeat_cnt != 16'hffff)) begin
            repeat_cnt <= repeat_cnt + 16'd1;
        end
    end

    // fetch one cycle ahead of each byte load
    // byte 0 while idle and before every wrap
    assign seq_mem_addr = (!sending || last_bit) ? '0 : bit_cnt_inc[MEM_ADDR_W+2:3];

    // shifter control
    assign shift_clear = (state == SEQ_SEND) && (next_state == SEQ_WAIT);
    assign shift_load  = (state == SEQ_SEND) && !shift_clear &&
                         (at_wrap || (bit_cnt[2:0] == 3'd0));
    assign shift_step  = (state == SEQ_SEND) && !shift_clear && !shift_load;

    // idle flag trails the state by one clock
    always_ff @(posedge CMD_CLK_IN) begin
        if (reset_sync || seq_clear) begin
            ready <= 1'b1;
        end else begin
            ready <= (state == SEQ_WAIT);
        end
    end

    // enable seen by the external start logic
    always_ff @(posedge CMD_CLK_IN) begin
        if (reset_sync) begin
            cmd_ext_start_enable <= 1'b0;
        end else begin
            cmd_ext_start_enable <= cfg.en_ext_start;
        end
    end

endmodule

// File: hdl/cmd_seq_shifter.sv
`timescale 1ns/1ps

module cmd_seq_shifter (
    input  logic       CMD_CLK_IN,
    input  logic       reset_sync,
    input  logic       seq_clear,
    input  logic [7:0] seq_mem_data,
    input  logic       shift_load,
    input  logic       shift_step,
    input  logic       shift_clear,
    output logic       cmd_data,
    cmd_cfg_if.shift_mp cfg
);

    logic [7:0] send_word;
    logic       data_pos;
    logic       data_neg;

    // current byte, msb is the next bit out
    always_ff @(posedge CMD_CLK_IN) begin
        if (reset_sync || seq_clear) begin
            send_word <= 8'h00;
        end else if (shift_clear) begin
            // line idles low after the last bit
            send_word <= 8'h00;
        end else if (shift_load) begin
            send_word <= seq_mem_data;
        end else if (shift_step) begin
            send_word <= {send_word[6:0], 1'b0};
        end
    end

    // rising edge launch
    always_ff @(posedge CMD_CLK_IN) begin
        if (reset_sync) begin
            data_pos <= 1'b0;
        end else begin
            data_pos <= send_word[7];
        end
    end

    // retimed half a period later
    always_ff @(negedge CMD_CLK_IN) begin
        data_neg <= data_pos;
    end

    // launch edge select
    assign cmd_data = cfg.en_negedge_data ? data_neg : data_pos;

endmodule

// File: hdl/cmd_seq_top.sv
`timescale 1ns/1ps

module cmd_seq_top import cmd_seq_pkg::*; (
    input  logic        CMD_CLK_IN,
    input  logic        reset_sync,
    input  logic [15:0] bus_add,
    input  logic [7:0]  bus_data_in,
    input  logic        bus_rd,
    input  logic        bus_wr,
    input  logic        cmd_ext_start_flag,
    output logic [7:0]  bus_data_out,
    output logic        cmd_clk_out,
    output logic        cmd_ext_start_enable,
    output logic        cmd_data,
    output logic        cmd_ready
);

    logic [MEM_ADDR_W-1:0] mem_rd_addr;
    logic [7:0]            mem_rd_data;
    logic [MEM_ADDR_W-1:0] seq_mem_addr;
    logic [7:0]            seq_mem_data;
    logic                  seq_start;
    logic                  seq_clear;
    logic                  shift_load;
    logic                  shift_step;
    logic                  shift_clear;
    logic                  ready;

    // configuration bundle
    cmd_cfg_if u_cfg ();

    // bus side registers and readback
    cmd_seq_regs u_regs (
        .CMD_CLK_IN   (CMD_CLK_IN),
        .reset_sync   (reset_sync),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .ready        (ready),
        .mem_rd_data  (mem_rd_data),
        .bus_data_out (bus_data_out),
        .mem_rd_addr  (mem_rd_addr),
        .seq_start    (seq_start),
        .seq_clear    (seq_clear),
        .cfg          (u_cfg.regs_mp)
    );

    cmd_seq_mem u_mem (
        .CMD_CLK_IN   (CMD_CLK_IN),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .mem_rd_addr  (mem_rd_addr),
        .seq_mem_addr (seq_mem_addr),
        .mem_rd_data  (mem_rd_data),
        .seq_mem_data (seq_mem_data)
    );

    // send sequencer
    cmd_seq_ctrl u_ctrl (
        .CMD_CLK_IN           (CMD_CLK_IN),
        .reset_sync           (reset_sync),
        .seq_start            (seq_start),
        .seq_clear            (seq_clear),
        .cmd_ext_start_flag   (cmd_ext_start_flag),
        .ready                (ready),
        .seq_mem_addr         (seq_mem_addr),
        .shift_load           (shift_load),
        .shift_step           (shift_step),
        .shift_clear          (shift_clear),
        .cmd_ext_start_enable (cmd_ext_start_enable),
        .cfg                  (u_cfg.ctrl_mp)
    );

    cmd_seq_shifter u_shifter (
        .CMD_CLK_IN   (CMD_CLK_IN),
        .reset_sync   (reset_sync),
        .seq_clear    (seq_clear),
        .seq_mem_data (seq_mem_data),
        .shift_load   (shift_load),
        .shift_step   (shift_step),
        .shift_clear  (shift_clear),
        .cmd_data     (cmd_data),
        .cfg          (u_cfg.shift_mp)
    );

    // clock forwarded ungated
    assign cmd_clk_out = CMD_CLK_IN;
    assign cmd_ready   = ready;

endmodule

// File: dv/cmd_seq_tb.sv
`timescale 1ns/1ps

module cmd_seq_tb import cmd_seq_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    // longest stream of every test in bits
    localparam int STREAM_BITS = 20 * 3 + 8 + 12 * 2 + 200 * 100;
    // bus traffic, reset and idle gaps
    localparam int MARGIN_CYCLES = 2000;

    logic        CMD_CLK_IN = 1'b0;
    logic        reset_sync;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_rd;
    logic        bus_wr;
    logic        cmd_ext_start_flag;
    logic [7:0]  bus_data_out;
    logic        cmd_clk_out;
    logic        cmd_ext_start_enable;
    logic        cmd_data;
    logic        cmd_ready;

    // current pattern bits in send order
    bit          pattern_q [$];

    cmd_seq_top u_cmd_seq_top (
        .CMD_CLK_IN           (CMD_CLK_IN),
        .reset_sync           (reset_sync),
        .bus_add              (bus_add),
        .bus_data_in          (bus_data_in),
        .bus_rd               (bus_rd),
        .bus_wr               (bus_wr),
        .cmd_ext_start_flag   (cmd_ext_start_flag),
        .bus_data_out         (bus_data_out),
        .cmd_clk_out          (cmd_clk_out),
        .cmd_ext_start_enable (cmd_ext_start_enable),
        .cmd_data             (cmd_data),
        .cmd_ready            (cmd_ready)
    );

    always #(CLK_PERIOD / 2) CMD_CLK_IN = ~CMD_CLK_IN;

    // watchdog
    initial begin
        #((STREAM_BITS + MARGIN_CYCLES) * CLK_PERIOD);
        fail_run("watchdog expired before the tests finished");
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [7:0] actual,
                           input logic [7:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h",
                               name, actual, expected));
        end
    endtask

    // one write cycle launched on the falling edge
    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(negedge CMD_CLK_IN);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(negedge CMD_CLK_IN);
        bus_wr      = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
        @(negedge CMD_CLK_IN);
        bus_add = addr;
        bus_rd  = 1'b1;
        @(negedge CMD_CLK_IN);
        // memory bytes need the read held one more cycle
        if (addr >= 16'(MEM_BASE)) begin
            @(negedge CMD_CLK_IN);
        end
        bus_rd = 1'b0;
        data   = bus_data_out;
    endtask

    task automatic check_read(input logic [15:0] addr, input logic [7:0] expected,
                              input string name);
        logic [7:0] data;
        bus_read(addr, data);
        compare(name, data, expected);
    endtask

    // bounded poll on falling edges
    task automatic wait_ready(input logic level, input int max_cycles);
        int cycles = 0;
        while (cmd_ready !== level) begin
            if (cycles == max_cycles) begin
                fail_run($sformatf("cmd_ready did not go to %0d within %0d cycles",
                                   level, max_cycles));
            end
            @(negedge CMD_CLK_IN);
            cycles++;
        end
    endtask

    task automatic set_config(input logic [7:0] conf, input logic [15:0] size,
                              input logic [15:0] repeats);
        bus_write(16'(REG_CONF), conf);
        bus_write(16'(REG_SIZE_LO), size[7:0]);
        bus_write(16'(REG_SIZE_HI), size[15:8]);
        bus_write(16'(REG_REPEAT_LO), repeats[7:0]);
        bus_write(16'(REG_REPEAT_HI), repeats[15:8]);
    endtask

    // random bytes from memory byte 0 up
    // expected bits kept msb first
    task automatic load_pattern(input int nbytes);
        logic [7:0] byte_val;
        pattern_q.delete();
        for (int i = 0; i < nbytes; i++) begin
            byte_val = 8'($urandom);
            bus_write(16'(MEM_BASE + i), byte_val);
            for (int b = 0; b < 8; b++) begin
                pattern_q.push_back(byte_val[7]);
                byte_val = byte_val << 1;
            end
        end
    endtask

    task automatic pulse_ext_start();
        @(negedge CMD_CLK_IN);
        cmd_ext_start_flag = 1'b1;
        @(negedge CMD_CLK_IN);
        cmd_ext_start_flag = 1'b0;
    endtask

    // bit 0 shows one edge after cmd_ready falls
    task automatic capture_stream(input int size, input int repeats, input bit negedge_mode);
        bit got;
        int total;
        total = size * repeats;
        wait_ready(1'b0, 8);
        // one extra sample for the idle low after the stream
        for (int n = 0; n <= total; n++) begin
            @(negedge CMD_CLK_IN);
            // falling edge launch is sampled mid period on the rising edge
            if (negedge_mode) begin
                @(posedge CMD_CLK_IN);
            end
            got = cmd_data;
            if (n < total) begin
                compare($sformatf("cmd_data bit %0d", n), 8'(got),
                        8'(pattern_q[n % size]));
            end else begin
                compare("cmd_data after stream", 8'(got), 8'h00);
            end
        end
        wait_ready(1'b1, 8);
    endtask

    // register defaults and idle flags
    task automatic check_defaults();
        check_read(16'(REG_CONF), 8'h02, "conf");
        check_read(16'(REG_SIZE_LO), 8'h00, "size_lo");
        check_read(16'(REG_SIZE_HI), 8'h00, "size_hi");
        check_read(16'(REG_REPEAT_LO), 8'h01, "repeat_lo");
        check_read(16'(REG_REPEAT_HI), 8'h00, "repeat_hi");
        check_read(16'(REG_SPARE), 8'h00, "spare");
        check_read(16'(REG_START), 8'h01, "ready flag");
        compare("cmd_ready", 8'(cmd_ready), 8'h01);
    endtask

    // forwarded clock sampled a quarter period into each level
    task automatic check_clk_forward();
        @(negedge CMD_CLK_IN);
        #(CLK_PERIOD / 4);
        compare("cmd_clk_out", 8'(cmd_clk_out), 8'h00);
        @(posedge CMD_CLK_IN);
        #(CLK_PERIOD / 4);
        compare("cmd_clk_out", 8'(cmd_clk_out), 8'h01);
    endtask

    task automatic expect_reset_state();
        compare("cmd_data", 8'(cmd_data), 8'h00);
        compare("cmd_ext_start_enable", 8'(cmd_ext_start_enable), 8'h00);
        check_defaults();
        check_clk_forward();
    endtask

    task automatic readback_mem_and_spare();
        logic [15:0] addr_q [$];
        logic [7:0]  val_q [$];
        logic [7:0]  spare_val;
        // one address per 256 byte block so none repeat
        for (int i = 0; i < 8; i++) begin
            addr_q.push_back(16'(MEM_BASE + i * 256 + int'($urandom_range(255))));
            val_q.push_back(8'($urandom));
            bus_write(addr_q[i], val_q[i]);
        end
        spare_val = 8'($urandom);
        bus_write(16'(REG_SPARE), spare_val);
        for (int i = 0; i < 8; i++) begin
            check_read(addr_q[i], val_q[i], $sformatf("mem at 0x%0h", addr_q[i]));
        end
        check_read(16'(REG_SPARE), spare_val, "spare");
    endtask

    task automatic posedge_repeat_send();
        set_config(8'h00, 16'd20, 16'd3);
        load_pattern(3);
        bus_write(16'(REG_START), 8'h01);
        capture_stream(20, 3, 1'b0);
    endtask

    task automatic negedge_single_send();
        set_config(8'h02, 16'd8, 16'd1);
        load_pattern(1);
        bus_write(16'(REG_START), 8'h01);
        capture_stream(8, 1, 1'b1);
    endtask

    task automatic ext_start_gating();
        set_config(8'h00, 16'd12, 16'd2);
        load_pattern(2);
        // pulse is ignored while the enable is clear
        pulse_ext_start();
        repeat (6) @(negedge CMD_CLK_IN);
        compare("cmd_ready", 8'(cmd_ready), 8'h01);
        bus_write(16'(REG_CONF), 8'h01);
        @(negedge CMD_CLK_IN);
        compare("cmd_ext_start_enable", 8'(cmd_ext_start_enable), 8'h01);
        pulse_ext_start();
        capture_stream(12, 2, 1'b0);
    endtask

    task automatic soft_reset_abort();
        set_config(8'h00, 16'd200, 16'd100);
        load_pattern(25);
        bus_write(16'(REG_START), 8'h01);
        wait_ready(1'b0, 8);
        repeat (50) @(negedge CMD_CLK_IN);
        compare("cmd_ready during send", 8'(cmd_ready), 8'h00);
        // abort mid stream
        bus_write(16'(REG_SOFT_RST), 8'h00);
        wait_ready(1'b1, 4);
        check_defaults();
    endtask

    initial begin
        void'($urandom(32090));
        reset_sync         = 1'b1;
        bus_add            = 16'h0000;
        bus_data_in        = 8'h00;
        bus_rd             = 1'b0;
        bus_wr             = 1'b0;
        cmd_ext_start_flag = 1'b0;
        repeat (3) @(posedge CMD_CLK_IN);
        @(negedge CMD_CLK_IN);
        reset_sync = 1'b0;

        expect_reset_state();
        readback_mem_and_spare();
        posedge_repeat_send();
        negedge_single_send();
        ext_start_gating();
        soft_reset_abort();

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: cmd_seq_top.f
hdl/cmd_seq_pkg.sv
hdl/cmd_cfg_if.sv
hdl/cmd_seq_regs.sv
hdl/cmd_seq_mem.sv
hdl/cmd_seq_ctrl.sv
hdl/cmd_seq_shifter.sv
hdl/cmd_seq_top.sv
dv/cmd_seq_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator from the project root, run, then look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module cmd_seq_tb -f cmd_seq_top.f &&
./obj_dir/Vcmd_seq_tb | tee /dev/stderr | grep -F 'All tests passed!' > /dev/null &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
